// ==== hdl/cu_setup_pkg.sv ====
// Shared widths, request FIFO sizing and cache-line granularity
// Address and count vector types, sequencer state enum
// Descriptor, read configuration, memory request and FIFO status structs

package cu_setup_pkg;

    // ------------------------------------------------------------
    // Widths and sizing
    // ------------------------------------------------------------
    localparam int addr_w           = 64;
    localparam int count_w          = 32;
    localparam int cache_line_bytes = 64;
    localparam int line_shift       = $clog2(cache_line_bytes);

    localparam int fifo_depth       = 32;
    localparam int fifo_prog_thresh = 16;
    // One extra bit so the fill counter can hold fifo_depth itself
    localparam int fifo_ptr_w       = $clog2(fifo_depth) + 1;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [count_w-1:0] count_t;

    // ------------------------------------------------------------
    // Sequencer states
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        st_reset,
        st_idle,
        st_req_start,
        st_req_busy,
        st_req_pause,
        st_req_done
    } setup_state_t;

    // ------------------------------------------------------------
    // Bundled signals
    // ------------------------------------------------------------
    typedef struct packed {
        logic   valid;
        addr_t  buffer_base;
        count_t buffer_count;
    } descriptor_t;

    // Read range handed to the serial read engine
    typedef struct packed {
        addr_t  base;
        count_t count;
    } read_config_t;

    // Offset carries the element index of the request
    typedef struct packed {
        logic   valid;
        addr_t  address;
        count_t offset;
    } mem_request_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
    } fifo_status_t;

endpackage

// ==== hdl/setup_descriptor_decode.sv ====
// Descriptor input register
// Maps the buffer base and element count onto the read configuration

`timescale 1ns/100ps

module setup_descriptor_decode (
    input  logic                       ap_clk,
    input  logic                       areset_cu_setup,
    input  cu_setup_pkg::descriptor_t  descriptor_in,
    output logic                       desc_valid,
    output cu_setup_pkg::read_config_t read_config
);

    // ------------------------------------------------------------
    // Descriptor valid
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            desc_valid <= 1'b0;
        end else begin
            desc_valid <= descriptor_in.valid;
        end
    end

    // ------------------------------------------------------------
    // Read range
    // ------------------------------------------------------------
    // Payload follows the input every cycle, qualified by desc_valid
    always_ff @(posedge ap_clk) begin
        read_config.base  <= descriptor_in.buffer_base;
        read_config.count <= descriptor_in.buffer_count;
    end

endmodule

// ==== hdl/setup_sequencer.sv ====
// Setup FSM that starts, pauses and completes the serial read engine
// Registered start, pause, config_valid and setup_done levels

`timescale 1ns/100ps

module setup_sequencer (
    input  logic                       ap_clk,
    input  logic                       areset_cu_setup,
    input  logic                       desc_valid,
    input  cu_setup_pkg::fifo_status_t fifo_status,
    input  logic                       engine_done,
    input  logic                       engine_ready,
    output logic                       start,
    output logic                       pause,
    output logic                       config_valid,
    output logic                       setup_done
);

    cu_setup_pkg::setup_state_t current_state;
    cu_setup_pkg::setup_state_t next_state;

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            current_state <= cu_setup_pkg::st_reset;
        end else begin
            current_state <= next_state;
        end
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        next_state = current_state;
        case (current_state)
            cu_setup_pkg::st_reset: begin
                next_state = cu_setup_pkg::st_idle;
            end
            cu_setup_pkg::st_idle: begin
                if (desc_valid && engine_done && engine_ready) begin
                    next_state = cu_setup_pkg::st_req_start;
                end
            end
            cu_setup_pkg::st_req_start: begin
                // Wait for the engine to acknowledge the start strobe
                if (!engine_done && !engine_ready) begin
                    next_state = cu_setup_pkg::st_req_busy;
                end
            end
            cu_setup_pkg::st_req_busy: begin
                if (engine_done && fifo_status.empty) begin
                    next_state = cu_setup_pkg::st_req_done;
                end else if (fifo_status.prog_full) begin
                    next_state = cu_setup_pkg::st_req_pause;
                end
            end
            cu_setup_pkg::st_req_pause: begin
                if (!fifo_status.prog_full) begin
                    next_state = cu_setup_pkg::st_req_busy;
                end
            end
            cu_setup_pkg::st_req_done: begin
                // Held until the descriptor is withdrawn
                if (!desc_valid) begin
                    next_state = cu_setup_pkg::st_idle;
                end
            end
            default: begin
                next_state = cu_setup_pkg::st_reset;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Registered outputs
    // ------------------------------------------------------------
    // Decoded from next_state so each level lines up with its state
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            start        <= 1'b0;
            pause        <= 1'b0;
            config_valid <= 1'b0;
            setup_done   <= 1'b0;
        end else begin
            start        <= (next_state == cu_setup_pkg::st_req_start);
            pause        <= (next_state == cu_setup_pkg::st_req_pause);
            config_valid <= (next_state == cu_setup_pkg::st_req_start) ||
                            (next_state == cu_setup_pkg::st_req_busy);
            setup_done   <= (next_state == cu_setup_pkg::st_req_done);
        end
    end

    // Engine leaves idle the cycle after it sees start
    assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        $rose(start) |=> (!engine_ready && !engine_done));

    // Done only after the request FIFO has been drained
    assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        $rose(setup_done) |-> fifo_status.empty);

endmodule

// ==== hdl/serial_read_engine.sv ====
// Serial read engine stepping through the element range
// One cache-line read request per element, stalled by pause

`timescale 1ns/100ps

module serial_read_engine (
    input  logic                       ap_clk,
    input  logic                       areset_cu_setup,
    input  cu_setup_pkg::read_config_t read_config,
    input  logic                       config_valid,
    input  logic                       start,
    input  logic                       pause,
    output cu_setup_pkg::mem_request_t req_push,
    output logic                       engine_ready,
    output logic                       engine_done
);

    logic                       running;
    logic                       emit;
    logic                       last;
    logic                       push_valid;
    cu_setup_pkg::read_config_t cfg;
    cu_setup_pkg::count_t       run_index;
    cu_setup_pkg::addr_t        push_address;
    cu_setup_pkg::count_t       push_offset;

    assign emit = running && (cfg.count != '0) && config_valid && !pause;
    assign last = (run_index == cfg.count - 1'b1);

    // ------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            running    <= 1'b0;
            push_valid <= 1'b0;
        end else begin
            push_valid <= emit;
            if (!running) begin
                running <= start;
            end else if (cfg.count == '0) begin
                // Empty range finishes without a request
                running <= 1'b0;
            end else if (emit && last) begin
                running <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Range, index and request payload
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!running && start) begin
            cfg       <= read_config;
            run_index <= '0;
        end else if (emit) begin
            run_index <= run_index + 1'b1;
        end
        push_address <= cfg.base + (cu_setup_pkg::addr_t'(run_index) << cu_setup_pkg::line_shift);
        push_offset  <= run_index;
    end

    always_comb begin
        req_push.valid   = push_valid;
        req_push.address = push_address;
        req_push.offset  = push_offset;
    end

    // Done waits for the last request to reach the FIFO
    assign engine_ready = !running;
    assign engine_done  = !running && !push_valid;

endmodule

// ==== hdl/request_fifo.sv ====
// Circular request buffer with fill counter
// Empty, full and programmable-full status
// Registered pop output

`timescale 1ns/100ps

module request_fifo (
    input  logic                       ap_clk,
    input  logic                       areset_cu_setup,
    input  cu_setup_pkg::mem_request_t req_push,
    input  logic                       request_rd_en,
    output cu_setup_pkg::mem_request_t request_out,
    output cu_setup_pkg::fifo_status_t fifo_status
);

    cu_setup_pkg::mem_request_t          mem [cu_setup_pkg::fifo_depth];
    logic [cu_setup_pkg::fifo_ptr_w-2:0] wr_ptr;
    logic [cu_setup_pkg::fifo_ptr_w-2:0] rd_ptr;
    logic [cu_setup_pkg::fifo_ptr_w-1:0] fill;
    logic                                wr_en;
    logic                                rd_en;
    logic                                out_valid;
    cu_setup_pkg::mem_request_t          out_entry;

    // ------------------------------------------------------------
    // Status
    // ------------------------------------------------------------
    always_comb begin
        fifo_status.empty     = (fill == '0);
        fifo_status.full      = (fill == cu_setup_pkg::fifo_ptr_w'(cu_setup_pkg::fifo_depth));
        fifo_status.prog_full =
            (fill >= cu_setup_pkg::fifo_ptr_w'(cu_setup_pkg::fifo_prog_thresh));
    end

    assign wr_en = req_push.valid && !fifo_status.full;
    assign rd_en = request_rd_en && !fifo_status.empty;

    // ------------------------------------------------------------
    // Pointers and fill level
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Storage and output register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= req_push;
        end
        if (rd_en) begin
            out_entry <= mem[rd_ptr];
        end
    end

    always_comb begin
        request_out         = out_entry;
        request_out.valid   = out_valid;
    end

    // Prog-full pause must leave room for requests still in flight
    assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        !(req_push.valid && fifo_status.full));

endmodule

// ==== hdl/cu_setup.sv ====
// Compute-unit setup top level
// Descriptor decode, setup sequencer, serial read engine and request FIFO

`timescale 1ns/100ps

module cu_setup (
    input  logic                       ap_clk,
    input  logic                       areset_cu_setup,
    input  cu_setup_pkg::descriptor_t  descriptor_in,
    input  logic                       request_rd_en,
    output cu_setup_pkg::mem_request_t request_out,
    output logic                       setup_done
);

    logic                       desc_valid;
    cu_setup_pkg::read_config_t read_config;
    logic                       start;
    logic                       pause;
    logic                       config_valid;
    logic                       engine_done;
    logic                       engine_ready;
    cu_setup_pkg::mem_request_t req_push;
    cu_setup_pkg::fifo_status_t fifo_status;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    setup_descriptor_decode u_decode (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor_in   (descriptor_in),
        .desc_valid      (desc_valid),
        .read_config     (read_config)
    );

    // ------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------
    setup_sequencer u_sequencer (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .desc_valid      (desc_valid),
        .fifo_status     (fifo_status),
        .engine_done     (engine_done),
        .engine_ready    (engine_ready),
        .start           (start),
        .pause           (pause),
        .config_valid    (config_valid),
        .setup_done      (setup_done)
    );

    serial_read_engine u_engine (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .read_config     (read_config),
        .config_valid    (config_valid),
        .start           (start),
        .pause           (pause),
        .req_push        (req_push),
        .engine_ready    (engine_ready),
        .engine_done     (engine_done)
    );

    // ------------------------------------------------------------
    // Result
    // ------------------------------------------------------------
    request_fifo u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .req_push        (req_push),
        .request_rd_en   (request_rd_en),
        .request_out     (request_out),
        .fifo_status     (fifo_status)
    );

endmodule

// ==== sim/clock_gen.sv ====
// Testbench clock and reset source
// 8 ns ap_clk, synchronous reset held for the first 3 cycles

`timescale 1ns/100ps

module clock_gen (
    output logic ap_clk,
    output logic areset_cu_setup
);

    // Half period of the 8 ns clock
    initial begin
        ap_clk = 1'b0;
        forever begin
            #4 ap_clk = ~ap_clk;
        end
    end

    // Released just after the third rising edge
    initial begin
        areset_cu_setup = 1'b1;
        repeat (3) @(posedge ap_clk);
        #1;
        areset_cu_setup = 1'b0;
    end

endmodule

// ==== sim/tb_cu_setup.sv ====
// Testbench for the compute-unit setup block
// Descriptor table with drain modes, request stream monitor, done handshake
// Compare tasks, cycle watchdog and final verdict

`timescale 1ns/100ps

module tb_cu_setup;

    typedef enum logic [1:0] {
        drain_always,
        drain_random,
        drain_stall
    } drain_mode_t;

    // One descriptor and the way the consumer drains it
    typedef struct packed {
        cu_setup_pkg::addr_t  base;
        cu_setup_pkg::count_t count;
        drain_mode_t          drain;
        cu_setup_pkg::count_t stall;
    } test_entry_t;

    logic                       ap_clk;
    logic                       areset_cu_setup;
    cu_setup_pkg::descriptor_t  descriptor_in;
    logic                       request_rd_en;
    cu_setup_pkg::mem_request_t request_out;
    logic                       setup_done;

    test_entry_t                test_table[$];
    cu_setup_pkg::mem_request_t expected_queue[$];
    cu_setup_pkg::count_t       entry_received;
    int unsigned                total_received;
    int unsigned                total_expected;
    int unsigned                cycle_count;
    int unsigned                cycle_limit;

    clock_gen u_clock_gen (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup)
    );

    cu_setup u_cu_setup (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor_in   (descriptor_in),
        .request_rd_en   (request_rd_en),
        .request_out     (request_out),
        .setup_done      (setup_done)
    );

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped after a failed check");
    endtask

    task automatic compare_address(input string name, input cu_setup_pkg::addr_t actual,
                                   input cu_setup_pkg::addr_t expected);
        if (actual !== expected) begin
            $display("ERR %0t %s actual=0x%h expected=0x%h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic compare_offset(input string name, input cu_setup_pkg::count_t actual,
                                  input cu_setup_pkg::count_t expected);
        if (actual !== expected) begin
            $display("ERR %0t %s actual=%0d expected=%0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic compare_count(input string name, input cu_setup_pkg::count_t actual,
                                 input cu_setup_pkg::count_t expected);
        if (actual !== expected) begin
            $display("ERR %0t %s actual=%0d expected=%0d", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic compare_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERR %0t %s actual=%b expected=%b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    function automatic test_entry_t make_entry(input cu_setup_pkg::addr_t base,
                                               input cu_setup_pkg::count_t count,
                                               input drain_mode_t drain,
                                               input cu_setup_pkg::count_t stall);
        test_entry_t entry;
        entry.base  = base;
        entry.count = count;
        entry.drain = drain;
        entry.stall = stall;
        return entry;
    endfunction

    // Counts above the FIFO depth with a stalled drain force the prog_full pause
    task automatic build_table();
        test_table.push_back(make_entry(64'h0000_0000_1000_0000, 32'd8,  drain_always, 32'd0));
        test_table.push_back(make_entry(64'h0000_0000_2000_0040, 32'd0,  drain_always, 32'd0));
        test_table.push_back(make_entry(64'h0000_0001_0000_0000, 32'd50, drain_stall,  32'd40));
        test_table.push_back(make_entry(64'h0000_0000_3000_0000, 32'd37, drain_random, 32'd0));
        test_table.push_back(make_entry(64'h0000_7fff_ffff_f000, 32'd20, drain_random, 32'd0));
        test_table.push_back(make_entry(64'h0000_0000_0000_0000, 32'd1,  drain_always, 32'd0));
        test_table.push_back(make_entry(64'h0000_0002_0000_1000, 32'd40, drain_stall,  32'd40));
    endtask

    // Pop-enable level for the given cycle of an entry
    function automatic logic drain_level(input test_entry_t entry, input int unsigned cycle);
        logic level;
        case (entry.drain)
            drain_always: level = 1'b1;
            drain_random: level = (($urandom % 2) == 1);
            drain_stall:  level = (cycle >= entry.stall);
            default:      level = 1'b1;
        endcase
        return level;
    endfunction

    task automatic check_idle_after_reset();
        int unsigned n;
        while (areset_cu_setup) begin
            @(negedge ap_clk);
        end
        for (n = 0; n < 4; n++) begin
            @(negedge ap_clk);
            compare_level("setup_done", setup_done, 1'b0);
            compare_level("request_out.valid", request_out.valid, 1'b0);
        end
    endtask

    task automatic run_entry(input test_entry_t entry);
        cu_setup_pkg::mem_request_t exp_req;
        cu_setup_pkg::count_t       i;
        int unsigned                entry_cycle;
        int unsigned                fall_wait;
        exp_req.valid = 1'b1;
        // Address rule: base plus element index times the cache-line size
        for (i = '0; i < entry.count; i = i + 1'b1) begin
            exp_req.address = entry.base + cu_setup_pkg::addr_t'(i) *
                              cu_setup_pkg::addr_t'(cu_setup_pkg::cache_line_bytes);
            exp_req.offset  = i;
            expected_queue.push_back(exp_req);
        end
        total_expected = total_expected + entry.count;
        entry_received = '0;

        @(posedge ap_clk);
        #1;
        descriptor_in.valid        = 1'b1;
        descriptor_in.buffer_base  = entry.base;
        descriptor_in.buffer_count = entry.count;
        entry_cycle   = 0;
        request_rd_en = drain_level(entry, entry_cycle);
        @(negedge ap_clk);
        while (!setup_done) begin
            @(posedge ap_clk);
            #1;
            entry_cycle++;
            request_rd_en = drain_level(entry, entry_cycle);
            @(negedge ap_clk);
        end

        @(posedge ap_clk);
        #1;
        compare_count("request count", entry_received, entry.count);
        descriptor_in.valid = 1'b0;
        request_rd_en       = 1'b1;
        fall_wait           = 0;
        @(negedge ap_clk);
        while (setup_done) begin
            fall_wait++;
            if (fall_wait > 4) begin
                $display("setup_done stayed high after the descriptor valid dropped");
                abort_run();
            end
            @(negedge ap_clk);
        end
    endtask

    // ------------------------------------------------------------
    // Output monitor and watchdog
    // ------------------------------------------------------------
    always @(negedge ap_clk) begin : monitor
        cu_setup_pkg::mem_request_t exp_req;
        if (!areset_cu_setup && request_out.valid) begin
            if (expected_queue.size() == 0) begin
                $display("Request for address 0x%h arrived with none outstanding",
                         request_out.address);
                abort_run();
            end else begin
                exp_req = expected_queue.pop_front();
                compare_address("request_out.address", request_out.address, exp_req.address);
                compare_offset("request_out.offset", request_out.offset, exp_req.offset);
                entry_received = entry_received + 1'b1;
                total_received = total_received + 1;
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles without finishing the table", cycle_count);
            abort_run();
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        int unsigned k;
        descriptor_in  = '0;
        request_rd_en  = 1'b0;
        entry_received = '0;
        total_received = 0;
        total_expected = 0;
        cycle_count    = 0;
        cycle_limit    = 0;
        void'($urandom(67672));
        build_table();
        for (k = 0; k < test_table.size(); k++) begin
            cycle_limit = cycle_limit + 4 * test_table[k].count + 100;
        end

        check_idle_after_reset();
        for (k = 0; k < test_table.size(); k++) begin
            run_entry(test_table[k]);
        end

        if (total_received == total_expected && expected_queue.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Received %0d requests where %0d were expected",
                     total_received, total_expected);
            abort_run();
        end
    end

endmodule

// ==== sources.f ====
hdl/cu_setup_pkg.sv
hdl/setup_descriptor_decode.sv
hdl/setup_sequencer.sv
hdl/serial_read_engine.sv
hdl/request_fifo.sv
hdl/cu_setup.sv
sim/clock_gen.sv
sim/tb_cu_setup.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cu_setup testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_cu_setup \
    -Mdir obj_dir \
    -o sim_cu_setup

# The simulator exits non-zero on a failed check; the log decides the verdict
./obj_dir/sim_cu_setup > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: passed"
    exit 0
else
    echo "run_sim: failed"
    exit 1
fi
